// File: src/adc_consts.svh
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

////////////////////
// adc part
`define ADC_W_SAMPLE     18    // bits per channel sample
`define ADC_N_CHAN       8     // four per serial line
`define ADC_MIN_T_CYCLE  160   // clk_in cycles per conversion, longer than one read
`define ADC_OS_MIN       1     // needed to fit all channels into one read
`define ADC_OS_MAX       6
`define ADC_W_OS         3

////////////////////
// register bus
`define ADC_W_WB_ADR     4     // word address
`define ADC_W_WB_DAT     32
`define ADC_W_FRAMES     16
`define ADC_REG_CTRL     0     // bit 0 is run
`define ADC_REG_OS       1
`define ADC_REG_FRAMES   2
`define ADC_REG_CH0      4     // channel n at word 4 + n

`endif

// File: src/adc_pkg.sv
`include "adc_consts.svh"

package adc_pkg;

	typedef logic signed [`ADC_W_SAMPLE-1:0] sample_t;       // one channel sample
	typedef logic [`ADC_W_OS-1:0] os_t;                     // oversampling code
	typedef logic [$clog2(`ADC_N_CHAN/2)-1:0] slot_t;       // word position on one line
	typedef logic [`ADC_W_WB_ADR-1:0] wb_adr_t;
	typedef logic [`ADC_W_WB_DAT-1:0] wb_dat_t;
	typedef logic [`ADC_W_FRAMES-1:0] frames_t;             // wraps

	// conversion engine
	typedef enum logic [1:0] {CV_IDLE, CV_CONVST, CV_CONV} cv_state_t;

	// serial read engine
	typedef enum logic [1:0] {RD_IDLE, RD_READ, RD_WAIT} rd_state_t;

endpackage

// File: src/adc_regs.sv
`include "adc_consts.svh"

module adc_regs (
	input  logic             clk_in,
	input  logic             reset_in,
	// wishbone classic slave
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  adc_pkg::wb_adr_t wb_adr,
	input  adc_pkg::wb_dat_t wb_dat_w,
	output adc_pkg::wb_dat_t wb_dat_r,
	output logic             wb_ack,
	// from serial reader
	input  logic             sample_valid,
	input  adc_pkg::slot_t   sample_slot,
	input  adc_pkg::sample_t sample_a,
	input  adc_pkg::sample_t sample_b,
	input  logic             frame_done,
	// control out
	output logic             run,
	output adc_pkg::os_t     os_out
);
	import adc_pkg::*;

	logic    access;                       // new access, ack not yet given
	logic    wr_en;
	os_t     os_clamped;
	frames_t frames;
	sample_t ch_mem [`ADC_N_CHAN];         // latest sample per channel
	wb_adr_t ch_off;                       // address relative to CH0
	logic    ch_hit;
	logic [$clog2(`ADC_N_CHAN)-1:0] ch_idx;
	wb_dat_t rd_data;

	assign access = wb_cyc && wb_stb && !wb_ack;
	assign wr_en  = access && wb_we;

	////////////////////
	// decode

	assign ch_off = wb_adr - wb_adr_t'(`ADC_REG_CH0);   // low addresses wrap high
	assign ch_hit = (ch_off < `ADC_N_CHAN);
	assign ch_idx = ch_off[$clog2(`ADC_N_CHAN)-1:0];

	// clamp on the full bus word so 9 lands on the max too
	always_comb begin
		if (wb_dat_w < wb_dat_t'(`ADC_OS_MIN)) begin
			os_clamped = os_t'(`ADC_OS_MIN);
		end else if (wb_dat_w > wb_dat_t'(`ADC_OS_MAX)) begin
			os_clamped = os_t'(`ADC_OS_MAX);
		end else begin
			os_clamped = os_t'(wb_dat_w);
		end
	end

	always_comb begin
		rd_data = '0;                       // unmapped reads as zero
		case (wb_adr)
			wb_adr_t'(`ADC_REG_CTRL):   rd_data = wb_dat_t'(run);
			wb_adr_t'(`ADC_REG_OS):     rd_data = wb_dat_t'(os_out);
			wb_adr_t'(`ADC_REG_FRAMES): rd_data = wb_dat_t'(frames);
			default: begin
				if (ch_hit) begin
					rd_data = wb_dat_t'(ch_mem[ch_idx]);   // signed source, sign extends
				end
			end
		endcase
	end

	////////////////////
	// registers

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			wb_ack <= 1'b0;
			run    <= 1'b0;
			os_out <= os_t'(`ADC_OS_MIN);
			frames <= '0;
		end else begin
			wb_ack <= access;                // one cycle, then drops
			if (wr_en && wb_adr == wb_adr_t'(`ADC_REG_CTRL)) begin
				run <= wb_dat_w[0];
			end
			if (wr_en && wb_adr == wb_adr_t'(`ADC_REG_OS)) begin
				os_out <= os_clamped;
			end
			if (frame_done) begin
				frames <= frames + 1'b1;      // wraps
			end
		end
	end

	// captured at the ack edge, so a same-cycle sample update is not seen
	always_ff @(posedge clk_in) begin
		if (access && !wb_we) begin
			wb_dat_r <= rd_data;
		end
	end

	// line a fills the lower half, line b the upper half
	always_ff @(posedge clk_in) begin
		if (sample_valid) begin
			ch_mem[{1'b0, sample_slot}] <= sample_a;
			ch_mem[{1'b1, sample_slot}] <= sample_b;
		end
	end

endmodule

// File: src/adc_convert_fsm.sv
`include "adc_consts.svh"

module adc_convert_fsm (
	input  logic clk_in,
	input  logic reset_in,
	input  logic run,
	input  logic busy_in,
	output logic convst_out
);
	import adc_pkg::*;

	cv_state_t state;
	cv_state_t state_next;
	logic [$clog2(`ADC_MIN_T_CYCLE)-1:0] cyc_cnt;   // cycles in current state
	logic cyc_done;

	// convst cycle plus the conv cycles make up the full period
	assign cyc_done = (cyc_cnt >= `ADC_MIN_T_CYCLE - 2);

	////////////////////
	// next state

	always_comb begin
		state_next = state;
		case (state)
			CV_IDLE: begin
				if (run) begin
					state_next = CV_CONVST;
				end
			end
			CV_CONVST: state_next = CV_CONV;   // pulse is one cycle
			CV_CONV: begin
				if (cyc_done && !busy_in) begin
					state_next = run ? CV_CONVST : CV_IDLE;
				end
			end
			default: state_next = CV_IDLE;
		endcase
	end

	////////////////////
	// state and counter

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state   <= CV_IDLE;
			cyc_cnt <= '0;
		end else begin
			state <= state_next;
			if (state_next != state) begin
				cyc_cnt <= '0;                  // restart on every change
			end else if (cyc_cnt != '1) begin
				cyc_cnt <= cyc_cnt + 1'b1;      // hold at max when busy is late
			end
		end
	end

	assign convst_out = (state != CV_CONVST);   // active low

endmodule

// File: src/adc_serial_reader.sv
`include "adc_consts.svh"

module adc_serial_reader (
	input  logic             clk_in,
	input  logic             reset_in,
	// adc pins
	input  logic             busy_in,
	input  logic             data_a_in,
	input  logic             data_b_in,
	output logic             n_cs_out,
	output logic             sclk_out,
	// sample strobes
	output logic             sample_valid,
	output adc_pkg::slot_t   sample_slot,
	output adc_pkg::sample_t sample_a,
	output adc_pkg::sample_t sample_b,
	output logic             frame_done
);
	import adc_pkg::*;

	rd_state_t state;
	logic      phase;                      // 0 first half of bit, 1 second
	logic [$clog2(`ADC_W_SAMPLE)-1:0] bit_cnt;   // bit within word
	slot_t     slot;                       // word within frame
	sample_t   sh_a;
	sample_t   sh_b;
	logic      word_end;
	logic      frame_end;

	assign word_end  = phase && (bit_cnt == `ADC_W_SAMPLE - 1);
	assign frame_end = word_end && (slot == slot_t'(`ADC_N_CHAN / 2 - 1));

	////////////////////
	// pins

	assign n_cs_out = (state != RD_READ);
	assign sclk_out = !(state == RD_READ && !phase);   // low in first half of each bit

	// shift regs hold the full word in the strobe cycle
	assign sample_a = sh_a;
	assign sample_b = sh_b;

	////////////////////
	// fsm

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: if (busy_in) state <= RD_READ;        // conversion under way
				RD_READ: if (frame_end) state <= RD_WAIT;      // 72 bits done
				RD_WAIT: if (!busy_in) state <= RD_IDLE;
				default: state <= RD_IDLE;
			endcase
		end
	end

	// phase and counters, held clear outside a read
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			phase        <= 1'b0;
			bit_cnt      <= '0;
			slot         <= '0;
			sample_valid <= 1'b0;
			sample_slot  <= '0;
			frame_done   <= 1'b0;
		end else begin
			sample_valid <= word_end;
			frame_done   <= frame_end;       // same cycle as last strobe
			if (word_end) begin
				sample_slot <= slot;
			end
			if (state != RD_READ) begin
				phase   <= 1'b0;
				bit_cnt <= '0;
				slot    <= '0;
			end else begin
				phase <= !phase;               // divide by two
				if (word_end) begin
					bit_cnt <= '0;
					slot    <= slot + 1'b1;
				end else if (phase) begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// msb first, taken while sclk is high
	always_ff @(posedge clk_in) begin
		if (state == RD_READ && phase) begin
			sh_a <= {sh_a[`ADC_W_SAMPLE-2:0], data_a_in};
			sh_b <= {sh_b[`ADC_W_SAMPLE-2:0], data_b_in};
		end
	end

endmodule

// File: src/adc_top.sv
module adc_top (
	input  logic             clk_in,
	input  logic             reset_in,
	// wishbone
	input  logic             wb_cyc,
	input  logic             wb_stb,
	input  logic             wb_we,
	input  adc_pkg::wb_adr_t wb_adr,
	input  adc_pkg::wb_dat_t wb_dat_w,
	output adc_pkg::wb_dat_t wb_dat_r,
	output logic             wb_ack,
	// adc
	input  logic             busy_in,
	input  logic             data_a_in,
	input  logic             data_b_in,
	output adc_pkg::os_t     os_out,
	output logic             convst_out,
	output logic             reset_out,
	output logic             sclk_out,
	output logic             n_cs_out
);
	import adc_pkg::*;

	logic    run;
	logic    sample_valid;
	slot_t   sample_slot;
	sample_t sample_a;
	sample_t sample_b;
	logic    frame_done;

	assign reset_out = reset_in;           // adc reset tracks system reset

	adc_regs u_regs (
		.clk_in, .reset_in,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.sample_valid, .sample_slot, .sample_a, .sample_b, .frame_done,
		.run, .os_out
	);

	adc_convert_fsm u_convert (
		.clk_in, .reset_in, .run, .busy_in, .convst_out
	);

	// reads the previous result while the next conversion runs
	adc_serial_reader u_reader (
		.clk_in, .reset_in, .busy_in, .data_a_in, .data_b_in,
		.n_cs_out, .sclk_out,
		.sample_valid, .sample_slot, .sample_a, .sample_b, .frame_done
	);

endmodule

// File: dv/adc_model.sv
`include "adc_consts.svh"

module adc_model (
	input  logic clk_in,
	input  logic reset_in,
	input  logic convst,                                  // active low start
	input  logic n_cs,
	input  logic sclk,
	input  logic [`ADC_N_CHAN*`ADC_W_SAMPLE-1:0] frame,   // channel n at bits n*18 up
	output logic busy,
	output logic data_a,
	output logic data_b
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUSY_CYCLES = 40;
	localparam int FRAME_BITS  = `ADC_N_CHAN / 2 * `ADC_W_SAMPLE;   // bits per line per read

	int busy_cnt;
	int fall_cnt;      // sclk falls so far, wraps once per read
	int bit_idx;       // bit now on the lines
	int word_idx;
	int pos;

	// busy rises the edge after convst is seen low
	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			busy     <= 1'b0;
			busy_cnt <= 0;
		end else if (!convst) begin
			busy     <= 1'b1;
			busy_cnt <= BUSY_CYCLES - 1;
		end else if (busy_cnt != 0) begin
			busy_cnt <= busy_cnt - 1;
		end else begin
			busy <= 1'b0;
		end
	end

	// first fall of a read puts out the msb of word 0
	always_ff @(negedge sclk or posedge reset_in) begin
		if (reset_in) begin
			fall_cnt <= 0;
			bit_idx  <= 0;
		end else begin
			bit_idx  <= fall_cnt;
			fall_cnt <= (fall_cnt == FRAME_BITS - 1) ? 0 : fall_cnt + 1;
		end
	end

	assign word_idx = bit_idx / `ADC_W_SAMPLE;
	assign pos      = `ADC_W_SAMPLE - 1 - bit_idx % `ADC_W_SAMPLE;   // msb first
	assign data_a   = !n_cs && frame[word_idx * `ADC_W_SAMPLE + pos];                  // ch 0..3
	assign data_b   = !n_cs && frame[(word_idx + `ADC_N_CHAN / 2) * `ADC_W_SAMPLE + pos];

endmodule

// File: dv/adc_chk.sv
module adc_chk (
	input logic clk_in,
	input logic reset_in,
	input logic convst_out,
	input logic n_cs_out,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] cs_low_cnt;   // low samples of n_cs in this read

	always_ff @(posedge clk_in or posedge reset_in) begin
		if (reset_in) begin
			cs_low_cnt <= '0;
		end else if (!n_cs_out) begin
			cs_low_cnt <= cs_low_cnt + 1'b1;
		end else begin
			cs_low_cnt <= '0;
		end
	end

	////////////////////
	// pin timing

	convst_one_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
		$fell(convst_out) |=> convst_out)
		else $error("convst_out low for more than one cycle");

	cs_read_length: assert property (@(posedge clk_in) disable iff (reset_in)
		$rose(n_cs_out) |-> cs_low_cnt == 8'd144)
		else $error("n_cs_out read window not 144 cycles");

	cs_read_max: assert property (@(posedge clk_in) disable iff (reset_in)
		!n_cs_out |-> cs_low_cnt < 8'd144)
		else $error("n_cs_out low past 144 cycles");

	ack_after_request: assert property (@(posedge clk_in) disable iff (reset_in)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without cyc and stb");

	ack_single: assert property (@(posedge clk_in) disable iff (reset_in)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high two cycles in a row");

endmodule

bind adc_top adc_chk u_chk (
	.clk_in(clk_in),
	.reset_in(reset_in),
	.convst_out(convst_out),
	.n_cs_out(n_cs_out),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack)
);

// File: dv/tb_adc_top.sv
`include "adc_consts.svh"

module tb_adc_top;
	timeunit 1ns;
	timeprecision 1ps;
	import adc_pkg::*;

	localparam int N_ROWS     = 5;
	localparam int ACK_LIMIT  = 16;    // cycles per bus access
	localparam int POLL_LIMIT = 100;   // frame counter polls

	logic    clk_in;
	logic    reset_in;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	logic    wb_ack;
	logic    busy;
	logic    data_a;
	logic    data_b;
	os_t     os_out;
	logic    convst_out;
	logic    reset_out;
	logic    sclk_out;
	logic    n_cs_out;
	logic [`ADC_N_CHAN*`ADC_W_SAMPLE-1:0] model_frame;   // words the adc hands out

	// os write, expected readback, channel values
	wb_dat_t os_wr_tab [N_ROWS]  = '{32'd0, 32'd3, 32'd7, 32'd9, 32'd2};
	os_t     os_exp_tab [N_ROWS] = '{3'd1, 3'd3, 3'd6, 3'd6, 3'd2};
	sample_t ch_tab [N_ROWS][`ADC_N_CHAN] = '{
		'{18'h00000, 18'h00001, 18'h3FFFF, 18'h1FFFF, 18'h20000, 18'h12345, 18'h2ABCD, 18'h0F0F0},
		'{18'h3FF00, 18'h000FF, 18'h15555, 18'h2AAAA, 18'h1FFFF, 18'h20000, 18'h00010, 18'h3FFF0},
		'{18'h20001, 18'h1FFFE, 18'h33333, 18'h0CCCC, 18'h00000, 18'h3FFFF, 18'h24680, 18'h13579},
		'{default: 18'h0},                  // random rows, filled at start
		'{default: 18'h0}
	};

	adc_top dut (
		.clk_in, .reset_in,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.busy_in(busy), .data_a_in(data_a), .data_b_in(data_b),
		.os_out, .convst_out, .reset_out, .sclk_out, .n_cs_out
	);

	adc_model u_adc (
		.clk_in, .reset_in(reset_out),
		.convst(convst_out), .n_cs(n_cs_out), .sclk(sclk_out), .frame(model_frame),
		.busy, .data_a, .data_b
	);

	initial begin
		clk_in = 1'b0;
		forever #10 clk_in = !clk_in;
	end

	////////////////////
	// helpers

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_in);
		#2;                                 // settle after the edge
	endtask

	task automatic report_timeout(input string what);
		$display("timeout waiting for %s", what);
		$display("test failed");
		$fatal(1, "timeout");
	endtask

	task automatic check_value(input string name, input wb_dat_t exp, input wb_dat_t got);
		assert (got === exp) else begin
			$display("[ERROR] %0d ns %s expected %h got %h", $time, name, exp, got);
			$display("test failed");
			$fatal(1, "mismatch");
		end
	endtask

	function automatic wb_dat_t sign_extend(input sample_t v);
		return {{(`ADC_W_WB_DAT - `ADC_W_SAMPLE){v[`ADC_W_SAMPLE-1]}}, v};
	endfunction

	// one classic cycle, held until ack
	task automatic bus_access(input logic we, input int adr, input wb_dat_t wdat,
			output wb_dat_t rdat);
		int n;
		n        = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = wb_adr_t'(adr);
		wb_dat_w = wdat;
		do begin
			wait_cycles(1);
			n++;
		end while (!wb_ack && n < ACK_LIMIT);
		if (!wb_ack)
			report_timeout("wb_ack");
		rdat   = wb_dat_r;                  // valid while ack high
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input int adr, input wb_dat_t wdat);
		wb_dat_t ignored;
		bus_access(1'b1, adr, wdat, ignored);
	endtask

	task automatic bus_read(input int adr, output wb_dat_t rdat);
		bus_access(1'b0, adr, '0, rdat);
	endtask

	task automatic read_expect(input string name, input int adr, input wb_dat_t exp);
		wb_dat_t rdat;
		bus_read(adr, rdat);
		check_value(name, exp, rdat);
	endtask

	// convst, and chip select and sclk if asked, stay high
	task automatic watch_quiet(input int n, input bit with_cs);
		repeat (n) begin
			wait_cycles(1);
			check_value("convst_out", 32'd1, wb_dat_t'(convst_out));
			if (with_cs) begin
				check_value("n_cs_out", 32'd1, wb_dat_t'(n_cs_out));
				check_value("sclk_out", 32'd1, wb_dat_t'(sclk_out));
			end
		end
	endtask

	task automatic wait_frames(input int n);
		wb_dat_t start;
		wb_dat_t now;
		int polls;
		polls = 0;
		bus_read(`ADC_REG_FRAMES, start);
		do begin
			wait_cycles(20);
			bus_read(`ADC_REG_FRAMES, now);
			polls++;
		end while (int'(frames_t'(now - start)) < n && polls < POLL_LIMIT);
		if (int'(frames_t'(now - start)) < n)
			report_timeout("FRAMES to advance");
	endtask

	task automatic check_channels(input int r);
		for (int c = 0; c < `ADC_N_CHAN; c++) begin
			read_expect($sformatf("ch%0d", c), `ADC_REG_CH0 + c, sign_extend(ch_tab[r][c]));
		end
	endtask

	////////////////////
	// sequence

	initial begin
		wb_dat_t f_a;
		wb_dat_t f_b;
		void'($urandom(32'h6414));
		reset_in    = 1'b1;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		model_frame = '0;
		for (int r = 3; r < N_ROWS; r++) begin
			for (int c = 0; c < `ADC_N_CHAN; c++) begin
				ch_tab[r][c] = sample_t'($urandom());
			end
		end
		wait_cycles(4);
		check_value("reset_out", 32'd1, wb_dat_t'(reset_out));   // adc held in reset too
		reset_in = 1'b0;

		// reset values, engines quiet
		read_expect("ctrl", `ADC_REG_CTRL, 32'd0);
		check_value("reset_out", 32'd0, wb_dat_t'(reset_out));
		read_expect("os", `ADC_REG_OS, 32'd1);
		read_expect("frames", `ADC_REG_FRAMES, 32'd0);
		check_value("os_out", 32'd1, wb_dat_t'(os_out));
		watch_quiet(300, 1'b1);

		// os clamp, then capture of the row's words
		for (int r = 0; r < N_ROWS; r++) begin
			bus_write(`ADC_REG_OS, os_wr_tab[r]);
			read_expect("os", `ADC_REG_OS, wb_dat_t'(os_exp_tab[r]));
			check_value("os_out", wb_dat_t'(os_exp_tab[r]), wb_dat_t'(os_out));
			for (int c = 0; c < `ADC_N_CHAN; c++) begin
				model_frame[c*`ADC_W_SAMPLE +: `ADC_W_SAMPLE] = ch_tab[r][c];
			end
			bus_write(`ADC_REG_CTRL, 32'd1);
			wait_frames(2);                 // first may be a mixed frame
			check_channels(r);
		end

		// frames move while running
		bus_read(`ADC_REG_FRAMES, f_a);
		wait_cycles(400);
		bus_read(`ADC_REG_FRAMES, f_b);
		assert (f_b != f_a) else begin
			$display("[ERROR] %0d ns frames expected change from %h got %h", $time, f_a, f_b);
			$display("test failed");
			$fatal(1, "frames stuck");
		end

		// stop, then nothing moves
		bus_write(`ADC_REG_CTRL, 32'd0);
		wait_cycles(400);
		bus_read(`ADC_REG_FRAMES, f_a);
		watch_quiet(400, 1'b0);
		read_expect("frames", `ADC_REG_FRAMES, f_a);

		// unmapped word 3
		bus_write(3, 32'hFFFF_FFFF);
		read_expect("word3", 3, 32'd0);
		read_expect("ctrl", `ADC_REG_CTRL, 32'd0);
		read_expect("os", `ADC_REG_OS, wb_dat_t'(os_exp_tab[N_ROWS-1]));
		read_expect("frames", `ADC_REG_FRAMES, f_a);
		check_channels(N_ROWS - 1);

		$display("test passed");
		$finish;
	end

endmodule

// File: all.f
+incdir+src
src/adc_pkg.sv
src/adc_regs.sv
src/adc_convert_fsm.sv
src/adc_serial_reader.sv
src/adc_top.sv
dv/adc_model.sv
dv/adc_chk.sv
dv/tb_adc_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f all.f --top-module tb_adc_top -o tb_adc_top \
	&& ./obj_dir/tb_adc_top > sim.log 2>&1 \
	|| echo "build or simulation stopped early: test failed" >> sim.log
cat sim.log
if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0
